/* common/wb_bridge_settings.svh */
/*
 * bridge width settings
 *  - physical byte address width
 *  - Wishbone data bus width
 *  - largest block command in bytes
 */

`ifndef WB_BRIDGE_SETTINGS_SVH
`define WB_BRIDGE_SETTINGS_SVH

// byte address of a memory command
`define WB_ADDR_WIDTH 32

// one data beat on the stream and on the bus
`define WB_DATA_WIDTH 64

// a cache block, the largest command size
`define WB_BLOCK_BYTES 64

`endif

/* common/wb_bridge_pkg.sv */
/*
 * shared bridge types
 *  - derived widths of the bus and the block
 *  - address, data, byte-select and beat-counter vectors
 *  - message type and size enums, command header struct
 */

`include "wb_bridge_settings.svh"

package wb_bridge_pkg;

  localparam int addr_width  = `WB_ADDR_WIDTH;
  localparam int data_width  = `WB_DATA_WIDTH;
  localparam int bus_bytes   = data_width / 8;
  // byte offset bits inside one bus word
  localparam int word_offset = $clog2(bus_bytes);
  localparam int max_beats   = `WB_BLOCK_BYTES / bus_bytes;

  typedef logic [addr_width-1:0]             paddr_t;
  typedef logic [data_width-1:0]             bus_data_t;
  typedef logic [bus_bytes-1:0]              byte_sel_t;
  typedef logic [addr_width-word_offset-1:0] wb_addr_t;
  typedef logic [$clog2(max_beats)-1:0]      beat_cnt_t;

  // uncached messages only
  typedef enum logic [1:0] {
    uc_rd = 2'b00,
    uc_wr = 2'b01
  } msg_type_e;

  // byte count is 2**code
  typedef enum logic [2:0] {
    size_1  = 3'd0,
    size_2  = 3'd1,
    size_4  = 3'd2,
    size_8  = 3'd3,
    size_16 = 3'd4,
    size_32 = 3'd5,
    size_64 = 3'd6
  } msg_size_e;

  typedef struct packed {
    msg_type_e msg_type;
    msg_size_e size;
    paddr_t    addr;
  } mem_header_t;

endpackage

/* common/mem_beat_if.sv */
/*
 * single beat channel between the bridge blocks
 *  - command header, beat address and beat data
 *  - valid/ready handshake with last marker
 *  - pump modport drives the beat, fsm modport consumes it
 */

`timescale 1ns/1ps

interface mem_beat_if;
  import wb_bridge_pkg::*;

  mem_header_t header;
  paddr_t      addr;
  bus_data_t   data;
  logic        valid;
  logic        ready;
  logic        last;

  // producer side
  modport pump (
    output header, addr, data, valid, last,
    input  ready
  );

  // consumer side
  modport fsm (
    input  header, addr, data, valid, last,
    output ready
  );

endinterface

/* rtl/bridge/cmd_stream_pump.sv */
/*
 * command stream pump
 *  - latches the header on the first beat of a command
 *  - forms beat addresses from the base address and a beat counter
 *  - passes write beats through, expands a read into its bus words
 */

`timescale 1ns/1ps

module cmd_stream_pump (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  wb_bridge_pkg::mem_header_t mem_cmd_header_i,
  input  wb_bridge_pkg::bus_data_t   mem_cmd_data_i,
  input  logic                       mem_cmd_v_i,
  input  logic                       mem_cmd_last_i,
  output logic                       mem_cmd_ready_o,
  mem_beat_if.pump                   cmd_beat_o
);
  import wb_bridge_pkg::*;

  mem_header_t            hdr_r;
  beat_cnt_t              cnt_r;
  logic                   active_r;

  mem_header_t            cur_hdr;
  beat_cnt_t              cur_cnt;
  beat_cnt_t              last_cnt;
  logic                   gen_rd;
  logic                   beat_fire;
  logic [word_offset-1:0] align_mask;

  // first beat comes straight from the stream
  assign cur_hdr = active_r ? hdr_r : mem_cmd_header_i;
  assign cur_cnt = active_r ? cnt_r : '0;

  // remaining read beats are made here, not taken from the stream
  assign gen_rd = active_r && (hdr_r.msg_type == uc_rd);

  // index of the final bus word of the command
  always_comb begin
    case (cur_hdr.size)
      size_16: last_cnt = beat_cnt_t'(1);
      size_32: last_cnt = beat_cnt_t'(3);
      size_64: last_cnt = beat_cnt_t'(7);
      default: last_cnt = '0;
    endcase
  end

  assign cmd_beat_o.header = cur_hdr;
  assign cmd_beat_o.addr   = cur_hdr.addr + paddr_t'({cur_cnt, {word_offset{1'b0}}});
  assign cmd_beat_o.data   = gen_rd ? '0 : mem_cmd_data_i;
  assign cmd_beat_o.valid  = gen_rd | mem_cmd_v_i;
  assign cmd_beat_o.last   = (cur_hdr.msg_type == uc_rd) ? (cur_cnt == last_cnt)
                                                         : mem_cmd_last_i;

  assign mem_cmd_ready_o = cmd_beat_o.ready & ~gen_rd;
  assign beat_fire       = cmd_beat_o.valid & cmd_beat_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_r <= 1'b0;
      cnt_r    <= '0;
    end else if (beat_fire) begin
      if (cmd_beat_o.last) begin
        active_r <= 1'b0;
        cnt_r    <= '0;
      end else begin
        active_r <= 1'b1;
        cnt_r    <= beat_cnt_t'(cur_cnt + 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire && !active_r) begin
      hdr_r <= mem_cmd_header_i;
    end
  end

  // required alignment, capped at one bus word
  always_comb begin
    case (mem_cmd_header_i.size)
      size_1:  align_mask = '0;
      size_2:  align_mask = {{(word_offset-1){1'b0}}, 1'b1};
      size_4:  align_mask = {{(word_offset-2){1'b0}}, 2'b11};
      default: align_mask = '1;
    endcase
  end

  hdr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_cmd_v_i && mem_cmd_ready_o && !active_r) |->
      ((mem_cmd_header_i.addr[word_offset-1:0] & align_mask) == '0))
    else $error("command address not aligned to its size");

  msg_type_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_cmd_v_i && !active_r) |-> (mem_cmd_header_i.msg_type inside {uc_rd, uc_wr}))
    else $error("command message type is not uncached");

endmodule

/* rtl/bridge/wb_master_fsm.sv */
/*
 * Wishbone master cycle FSM
 *  - registered cyc/stb, one single transfer per command beat
 *  - byte selects, write enable and word address from the beat
 *  - forwards each ack with the read data to the response side
 */

`timescale 1ns/1ps

module wb_master_fsm (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  mem_beat_if.fsm                  cmd_beat_i,
  mem_beat_if.pump                 resp_beat_o,
  output wb_bridge_pkg::wb_addr_t  adr_o,
  output wb_bridge_pkg::bus_data_t dat_o,
  output wb_bridge_pkg::byte_sel_t sel_o,
  output logic                     we_o,
  output logic                     cyc_o,
  output logic                     stb_o,
  input  wb_bridge_pkg::bus_data_t dat_i,
  input  logic                     ack_i
);
  import wb_bridge_pkg::*;

  typedef enum logic [1:0] {
    st_reset    = 2'b00,
    st_wait_cmd = 2'b01,
    st_wait_ack = 2'b10
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   cyc_n;
  logic   stb_n;
  logic   bus_ack;

  // bus fields follow the pending beat, which holds until ack
  assign adr_o = cmd_beat_i.addr[addr_width-1:word_offset];
  assign dat_o = cmd_beat_i.data;
  assign we_o  = (cmd_beat_i.header.msg_type == uc_wr);

  always_comb begin
    case (cmd_beat_i.header.size)
      size_1:  sel_o = byte_sel_t'(8'h01);
      size_2:  sel_o = byte_sel_t'(8'h03);
      size_4:  sel_o = byte_sel_t'(8'h0f);
      // full word for 8 bytes and every block beat
      default: sel_o = '1;
    endcase
  end

  assign bus_ack = ack_i & cyc_o;

  assign cmd_beat_i.ready   = bus_ack;
  assign resp_beat_o.valid  = bus_ack;
  assign resp_beat_o.header = cmd_beat_i.header;
  assign resp_beat_o.addr   = cmd_beat_i.addr;
  assign resp_beat_o.data   = dat_i;
  assign resp_beat_o.last   = cmd_beat_i.last;

  always_comb begin
    state_n = state_r;
    cyc_n   = 1'b0;
    stb_n   = 1'b0;
    case (state_r)
      st_reset: begin
        state_n = st_wait_cmd;
      end
      // start only when the response buffer has room
      st_wait_cmd: begin
        if (cmd_beat_i.valid && resp_beat_o.ready) begin
          cyc_n   = 1'b1;
          stb_n   = 1'b1;
          state_n = st_wait_ack;
        end
      end
      st_wait_ack: begin
        cyc_n = ~ack_i;
        stb_n = ~ack_i;
        if (ack_i) begin
          state_n = st_wait_cmd;
        end
      end
      default: begin
        state_n = st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= st_reset;
      cyc_o   <= 1'b0;
      stb_o   <= 1'b0;
    end else begin
      state_r <= state_n;
      cyc_o   <= cyc_n;
      stb_o   <= stb_n;
    end
  end

  stb_in_cyc_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stb_o |-> (cyc_o && cmd_beat_i.valid))
    else $error("stb high outside a bus cycle or without a pending beat");

  ack_in_cyc_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i |-> cyc_o)
    else $error("slave ack without an open cycle");

endmodule

/* rtl/bridge/resp_stream_pump.sv */
/*
 * response stream pump
 *  - one-entry buffer between bus acks and the response stream
 *  - replicates sub-word read data across all byte lanes
 *  - folds the acks of a write into a single zero-data response
 */

`timescale 1ns/1ps

module resp_stream_pump (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  mem_beat_if.fsm                    resp_beat_i,
  output wb_bridge_pkg::mem_header_t mem_resp_header_o,
  output wb_bridge_pkg::bus_data_t   mem_resp_data_o,
  output logic                       mem_resp_v_o,
  output logic                       mem_resp_last_o,
  input  logic                       mem_resp_ready_i
);
  import wb_bridge_pkg::*;

  logic        full_r;
  mem_header_t hdr_r;
  bus_data_t   data_r;
  logic        last_r;

  bus_data_t   rd_data;
  logic        is_wr;
  logic        capture;
  logic        pop;

  assign is_wr = (resp_beat_i.header.msg_type == uc_wr);

  // empty buffer lets the FSM open the next cycle
  assign resp_beat_i.ready = ~full_r;

  // only the final write ack becomes a response
  assign capture = resp_beat_i.valid && !full_r && (!is_wr || resp_beat_i.last);
  assign pop     = full_r && mem_resp_ready_i;

  // copy the low 2**size bytes into every lane
  always_comb begin
    case (resp_beat_i.header.size)
      size_1:  rd_data = {bus_bytes{resp_beat_i.data[7:0]}};
      size_2:  rd_data = {(bus_bytes/2){resp_beat_i.data[15:0]}};
      size_4:  rd_data = {(bus_bytes/4){resp_beat_i.data[31:0]}};
      default: rd_data = resp_beat_i.data;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (capture) begin
      full_r <= 1'b1;
    end else if (pop) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      hdr_r  <= resp_beat_i.header;
      data_r <= is_wr ? '0 : rd_data;
      last_r <= resp_beat_i.last;
    end
  end

  assign mem_resp_v_o      = full_r;
  assign mem_resp_header_o = hdr_r;
  assign mem_resp_data_o   = data_r;
  assign mem_resp_last_o   = last_r;

  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_resp_v_o && !mem_resp_ready_i) |=>
      (mem_resp_v_o && $stable(mem_resp_header_o) && $stable(mem_resp_data_o)
       && $stable(mem_resp_last_o)))
    else $error("response changed before it was accepted");

endmodule

/* rtl/mem_wb_bridge.sv */
/*
 * memory command stream to Wishbone B4 master bridge
 *  - command pump, bus FSM and response pump
 *  - beat interfaces between the three blocks
 */

`timescale 1ns/1ps

module mem_wb_bridge (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // command stream
  input  wb_bridge_pkg::mem_header_t mem_cmd_header_i,
  input  wb_bridge_pkg::bus_data_t   mem_cmd_data_i,
  input  logic                       mem_cmd_v_i,
  input  logic                       mem_cmd_last_i,
  output logic                       mem_cmd_ready_o,

  // response stream
  output wb_bridge_pkg::mem_header_t mem_resp_header_o,
  output wb_bridge_pkg::bus_data_t   mem_resp_data_o,
  output logic                       mem_resp_v_o,
  output logic                       mem_resp_last_o,
  input  logic                       mem_resp_ready_i,

  // Wishbone master
  output wb_bridge_pkg::wb_addr_t    adr_o,
  output wb_bridge_pkg::bus_data_t   dat_o,
  output wb_bridge_pkg::byte_sel_t   sel_o,
  output logic                       we_o,
  output logic                       cyc_o,
  output logic                       stb_o,
  input  wb_bridge_pkg::bus_data_t   dat_i,
  input  logic                       ack_i
);

  mem_beat_if cmd_beat ();
  mem_beat_if resp_beat ();

  cmd_stream_pump cmd_pump (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mem_cmd_header_i (mem_cmd_header_i),
    .mem_cmd_data_i   (mem_cmd_data_i),
    .mem_cmd_v_i      (mem_cmd_v_i),
    .mem_cmd_last_i   (mem_cmd_last_i),
    .mem_cmd_ready_o  (mem_cmd_ready_o),
    .cmd_beat_o       (cmd_beat.pump)
  );

  wb_master_fsm wb_fsm (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_beat_i  (cmd_beat.fsm),
    .resp_beat_o (resp_beat.pump),
    .adr_o       (adr_o),
    .dat_o       (dat_o),
    .sel_o       (sel_o),
    .we_o        (we_o),
    .cyc_o       (cyc_o),
    .stb_o       (stb_o),
    .dat_i       (dat_i),
    .ack_i       (ack_i)
  );

  resp_stream_pump resp_pump (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .resp_beat_i       (resp_beat.fsm),
    .mem_resp_header_o (mem_resp_header_o),
    .mem_resp_data_o   (mem_resp_data_o),
    .mem_resp_v_o      (mem_resp_v_o),
    .mem_resp_last_o   (mem_resp_last_o),
    .mem_resp_ready_i  (mem_resp_ready_i)
  );

endmodule

/* sim/wb_mem_model.sv */
/*
 * Wishbone slave memory for the bridge testbench
 *  - 256 words of 64 bits, filled from the byte address
 *  - random ack delay of 0 to 3 cycles per transfer
 *  - byte-select writes and registered read data
 */

`timescale 1ns/1ps

module wb_mem_model #(
  parameter int seed_init = 24022
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  wb_bridge_pkg::wb_addr_t  adr_i,
  input  wb_bridge_pkg::bus_data_t dat_i,
  input  wb_bridge_pkg::byte_sel_t sel_i,
  input  logic                     we_i,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  output wb_bridge_pkg::bus_data_t dat_o,
  output logic                     ack_o
);
  import wb_bridge_pkg::*;

  bus_data_t mem [0:255];
  integer    seed;
  int        delay;
  int        wait_cnt;

  // byte value at a byte address of the 2 KB window
  function automatic logic [7:0] fill_byte(logic [10:0] a);
    return a[7:0] ^ {5'b10110, a[10:8]};
  endfunction

  initial begin
    seed = seed_init;
    for (int w = 0; w < 256; w++) begin
      for (int l = 0; l < 8; l++) begin
        mem[w][l*8 +: 8] = fill_byte(11'(w * 8 + l));
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o    <= 1'b0;
      delay    <= 0;
      wait_cnt <= 0;
    end else if (ack_o) begin
      // one-cycle ack, the master drops cyc on the same edge
      ack_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt >= delay) begin
        ack_o    <= 1'b1;
        wait_cnt <= 0;
        delay    <= $random(seed) & 3;
        if (we_i) begin
          for (int l = 0; l < 8; l++) begin
            if (sel_i[l]) begin
              mem[adr_i[7:0]][l*8 +: 8] = dat_i[l*8 +: 8];
            end
          end
        end else begin
          dat_o <= mem[adr_i[7:0]];
        end
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

endmodule

/* sim/tb_mem_wb_bridge.sv */
/*
 * testbench for the memory command to Wishbone bridge
 *  - command table applied in a loop, reference byte memory
 *  - typed compare tasks for header, data, last and byte selects
 *  - bus monitor for cyc/stb/ack rules and the transfer count
 */

`timescale 1ns/1ps

module tb_mem_wb_bridge;
  import wb_bridge_pkg::*;

  typedef struct packed {
    logic [2:0] test_id;
    msg_type_e  msg_type;
    msg_size_e  size;
    paddr_t     addr;
    logic [7:0] tag;
    logic       stall;
  } cmd_row_t;

  localparam int wait_limit = 100;
  localparam int num_rows   = 19;

  // test, type, size, address, write data tag, response back-pressure
  localparam cmd_row_t rows [num_rows] = '{
    '{3'd1, uc_wr, size_8,  32'h040, 8'h11, 1'b0},
    '{3'd1, uc_rd, size_8,  32'h040, 8'h00, 1'b0},
    '{3'd2, uc_wr, size_1,  32'h108, 8'h21, 1'b0},
    '{3'd2, uc_rd, size_1,  32'h108, 8'h00, 1'b0},
    '{3'd2, uc_rd, size_8,  32'h108, 8'h00, 1'b0},
    '{3'd2, uc_wr, size_2,  32'h110, 8'h22, 1'b0},
    '{3'd2, uc_rd, size_2,  32'h110, 8'h00, 1'b0},
    '{3'd2, uc_rd, size_8,  32'h110, 8'h00, 1'b0},
    '{3'd2, uc_wr, size_4,  32'h118, 8'h23, 1'b0},
    '{3'd2, uc_rd, size_4,  32'h118, 8'h00, 1'b0},
    '{3'd2, uc_rd, size_8,  32'h118, 8'h00, 1'b0},
    '{3'd3, uc_wr, size_64, 32'h200, 8'h31, 1'b0},
    '{3'd3, uc_rd, size_64, 32'h200, 8'h00, 1'b0},
    '{3'd4, uc_rd, size_64, 32'h200, 8'h00, 1'b1},
    '{3'd4, uc_wr, size_32, 32'h300, 8'h41, 1'b1},
    '{3'd4, uc_rd, size_32, 32'h300, 8'h00, 1'b1},
    '{3'd4, uc_rd, size_16, 32'h0c0, 8'h00, 1'b1},
    '{3'd4, uc_rd, size_4,  32'h118, 8'h00, 1'b1},
    '{3'd4, uc_rd, size_8,  32'h7f8, 8'h00, 1'b1}
  };

  logic        clk_i;
  logic        rst_n_i;
  mem_header_t mem_cmd_header_i;
  bus_data_t   mem_cmd_data_i;
  logic        mem_cmd_v_i;
  logic        mem_cmd_last_i;
  logic        mem_cmd_ready_o;
  mem_header_t mem_resp_header_o;
  bus_data_t   mem_resp_data_o;
  logic        mem_resp_v_o;
  logic        mem_resp_last_o;
  logic        mem_resp_ready_i;
  wb_addr_t    adr_o;
  bus_data_t   dat_o;
  byte_sel_t   sel_o;
  logic        we_o;
  logic        cyc_o;
  logic        stb_o;
  bus_data_t   dat_i;
  logic        ack_i;

  logic [7:0]  ref_mem [0:2047];
  wb_addr_t    xfer_adr [$];
  bus_data_t   xfer_dat [$];
  byte_sel_t   xfer_sel [$];
  logic        xfer_we [$];
  int          xfer_total;
  int          exp_xfers;
  integer      seed;
  logic        row_ok;
  logic        aborted;
  logic        ack_prev;
  int          fail_count;
  int          tests_ok;
  int          tests_bad;

  mem_wb_bridge DUT (.*);

  wb_mem_model #(.seed_init(24022)) mem_model (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .adr_i (adr_o), .dat_i (dat_o), .sel_i (sel_o),
    .we_i (we_o), .cyc_i (cyc_o), .stb_i (stb_o), .dat_o (dat_i), .ack_o (ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [7:0] fill_byte(logic [10:0] a);
    return a[7:0] ^ {5'b10110, a[10:8]};
  endfunction

  function automatic bus_data_t make_wdata(logic [7:0] tag, int beat);
    bus_data_t w;
    for (int l = 0; l < 8; l++) w[l*8 +: 8] = tag + 8'(beat * 16 + l * 3);
    return w;
  endfunction

  // sub-word reads come back copied into every lane
  function automatic bus_data_t read_word(paddr_t addr, int nbytes);
    bus_data_t w;
    int        span;
    span = (nbytes < 8) ? nbytes : 8;
    for (int l = 0; l < 8; l++) w[l*8 +: 8] = ref_mem[11'(addr + paddr_t'(l % span))];
    return w;
  endfunction

  function automatic int num_words(msg_size_e size);
    return (size > size_8) ? (1 << (int'(size) - 3)) : 1;
  endfunction

  function automatic byte_sel_t expected_sel(msg_size_e size);
    return (size < size_8) ? byte_sel_t'((16'd1 << (1 << int'(size))) - 1) : '1;
  endfunction

  task automatic report_error(string msg);
    $display("Error at %0t: %s", $time, msg);
    fail_count++;
    row_ok = 1'b0;
  endtask

  task automatic check_header(string name, mem_header_t got, mem_header_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_count++;
      row_ok = 1'b0;
    end
  endtask

  task automatic check_data(string name, bus_data_t got, bus_data_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_count++;
      row_ok = 1'b0;
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      fail_count++;
      row_ok = 1'b0;
    end
  endtask

  task automatic check_sel(string name, byte_sel_t got, byte_sel_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_count++;
      row_ok = 1'b0;
    end
  endtask

  task automatic check_addr(string name, wb_addr_t got, wb_addr_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_count++;
      row_ok = 1'b0;
    end
  endtask

  task automatic close_test(string label);
    $display("%s: %s", label, row_ok ? "ok" : "mismatch");
    if (row_ok) tests_ok++;
    else tests_bad++;
  endtask

  // samples one ns after the falling edge, where every output is settled
  initial begin
    ack_prev   = 1'b0;
    xfer_total = 0;
    forever begin
      @(negedge clk_i);
      #1;
      if (rst_n_i) begin
        if (stb_o && !cyc_o) report_error("stb_o is high while cyc_o is low");
        if (ack_i && !cyc_o) report_error("ack_i arrived outside a bus cycle");
        if (ack_prev && cyc_o) report_error("cyc_o did not fall after ack");
        if (mem_resp_v_o && cyc_o) report_error("bus cycle open while a response waits");
        if (ack_i && cyc_o) begin
          xfer_adr.push_back(adr_o);
          xfer_dat.push_back(dat_o);
          xfer_sel.push_back(sel_o);
          xfer_we.push_back(we_o);
          xfer_total++;
        end
        ack_prev = ack_i && cyc_o;
      end
    end
  end

  task automatic send_beat(mem_header_t hdr, bus_data_t data, logic last);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < wait_limit) begin
      @(negedge clk_i);
      mem_cmd_header_i = hdr;
      mem_cmd_data_i   = data;
      mem_cmd_last_i   = last;
      mem_cmd_v_i      = 1'b1;
      mem_resp_ready_i = 1'b0;
      #1;
      done = mem_cmd_ready_o;
      waited++;
    end
    if (!done) begin
      report_error("command beat was never accepted");
      aborted = 1'b1;
    end
  endtask

  task automatic expect_resp(logic stall, mem_header_t hdr, bus_data_t data, logic last);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < wait_limit) begin
      @(negedge clk_i);
      mem_cmd_v_i      = 1'b0;
      mem_resp_ready_i = stall ? (($random(seed) & 3) == 0) : 1'b1;
      #1;
      done = mem_resp_v_o && mem_resp_ready_i;
      waited++;
    end
    if (!done) begin
      report_error("response beat never arrived");
      aborted = 1'b1;
    end else begin
      check_header("mem_resp_header_o", mem_resp_header_o, hdr);
      check_data("mem_resp_data_o", mem_resp_data_o, data);
      check_last("mem_resp_last_o", mem_resp_last_o, last);
    end
  endtask

  task automatic run_row(int idx);
    cmd_row_t    row;
    mem_header_t hdr;
    bus_data_t   wdata;
    int          words;
    int          nbytes;
    row          = rows[idx];
    hdr.msg_type = row.msg_type;
    hdr.size     = row.size;
    hdr.addr     = row.addr;
    words        = num_words(row.size);
    nbytes       = 1 << int'(row.size);
    row_ok       = 1'b1;
    exp_xfers   += words;
    xfer_adr.delete();
    xfer_dat.delete();
    xfer_sel.delete();
    xfer_we.delete();
    if (row.msg_type == uc_wr) begin
      for (int b = 0; b < words && !aborted; b++) begin
        wdata = make_wdata(row.tag, b);
        send_beat(hdr, wdata, b == words - 1);
        for (int l = 0; l < ((nbytes < 8) ? nbytes : 8); l++) begin
          ref_mem[11'(row.addr + paddr_t'(8 * b + l))] = wdata[l*8 +: 8];
        end
      end
      // one zero-data response for the whole write
      if (!aborted) expect_resp(row.stall, hdr, '0, 1'b1);
    end else begin
      send_beat(hdr, '0, 1'b1);
      for (int b = 0; b < words && !aborted; b++) begin
        expect_resp(row.stall, hdr, read_word(row.addr + paddr_t'(8 * b), nbytes),
                    b == words - 1);
      end
    end
    if (!aborted && xfer_adr.size() != words) begin
      report_error($sformatf("%0d bus transfers seen, %0d expected", xfer_adr.size(), words));
    end else if (!aborted) begin
      for (int b = 0; b < words; b++) begin
        check_addr("adr_o", xfer_adr[b], wb_addr_t'((row.addr >> 3) + b));
        check_sel("sel_o", xfer_sel[b], expected_sel(row.size));
        check_last("we_o", xfer_we[b], row.msg_type == uc_wr);
        if (row.msg_type == uc_wr) begin
          check_data("dat_o", xfer_dat[b], make_wdata(row.tag, b));
        end
      end
    end
    close_test($sformatf("test %0d row %0d, %s of %0d bytes at 0x%h", row.test_id, idx,
                         (row.msg_type == uc_wr) ? "write" : "read", nbytes, row.addr));
  endtask

  initial begin
    seed             = 24022;
    aborted          = 1'b0;
    fail_count       = 0;
    tests_ok         = 0;
    tests_bad        = 0;
    exp_xfers        = 0;
    rst_n_i          = 1'b0;
    mem_cmd_header_i = '0;
    mem_cmd_data_i   = '0;
    mem_cmd_v_i      = 1'b0;
    mem_cmd_last_i   = 1'b0;
    mem_resp_ready_i = 1'b0;
    for (int a = 0; a < 2048; a++) ref_mem[a] = fill_byte(11'(a));
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    row_ok = 1'b1;
    check_last("cyc_o", cyc_o, 1'b0);
    check_last("stb_o", stb_o, 1'b0);
    check_last("mem_resp_v_o", mem_resp_v_o, 1'b0);
    check_last("mem_cmd_ready_o", mem_cmd_ready_o, 1'b0);
    close_test("test 1 reset state");
    for (int i = 0; i < num_rows && !aborted; i++) run_row(i);
    if (!aborted) begin
      row_ok = 1'b1;
      // bus and response side stay quiet once the table is done
      repeat (8) begin
        @(negedge clk_i);
        #1;
        if (mem_resp_v_o) report_error("extra response beat after the last command");
      end
      if (xfer_total != exp_xfers) begin
        report_error($sformatf("%0d bus transfers in total, %0d expected", xfer_total,
                               exp_xfers));
      end
      close_test($sformatf("test 5 bus rules over %0d transfers", xfer_total));
    end
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_ok, tests_bad,
             fail_count);
    if (fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+common
common/wb_bridge_pkg.sv
common/mem_beat_if.sv
rtl/bridge/cmd_stream_pump.sv
rtl/bridge/wb_master_fsm.sv
rtl/bridge/resp_stream_pump.sv
rtl/mem_wb_bridge.sv
sim/wb_mem_model.sv
sim/tb_mem_wb_bridge.sv

/* Bender.yml */
package:
  name: mem_wb_bridge

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/wb_bridge_pkg.sv
      - common/mem_beat_if.sv
      - rtl/bridge/cmd_stream_pump.sv
      - rtl/bridge/wb_master_fsm.sv
      - rtl/bridge/resp_stream_pump.sv
      - rtl/mem_wb_bridge.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/tb_mem_wb_bridge.sv
